/* hdl/dmac_consts.svh */
`ifndef DMAC_CONSTS_SVH
`define DMAC_CONSTS_SVH

// Bus widths
`define DMAC_ADDR_WIDTH 32
`define DMAC_DATA_WIDTH 32

// Config fields, len n means n+1 beats
`define DMAC_LEN_BITS   8
`define DMAC_SIZE_BITS  3
`define DMAC_BURST_BITS 2

`define DMAC_CFG_LEN_LSB   0
`define DMAC_CFG_SIZE_LSB  8
`define DMAC_CFG_BURST_LSB 11

// Register map
`define DMAC_REG_SRC    32'h0000_0000
`define DMAC_REG_DST    32'h0000_0004
`define DMAC_REG_CONFIG 32'h0000_0008
`define DMAC_REG_VALID  32'h0000_000C

`define DMAC_FIFO_DEPTH 4
`define DMAC_CNT_BITS   ($clog2((`DMAC_FIFO_DEPTH) + 1))

`endif

/* hdl/dmac_pkg.sv */
`include "dmac_consts.svh"

package dmac_pkg;

    typedef enum logic [`DMAC_BURST_BITS-1:0] {
        BURST_FIXED = 2'd0,
        BURST_INCR  = 2'd1
    } burst_e;

    typedef logic [`DMAC_DATA_WIDTH-1:0] word_t;

    // Address increment per beat, any non-FIXED burst counts as INCR
    function automatic logic [`DMAC_ADDR_WIDTH-1:0] addr_step(
        input burst_e                      burst,
        input logic [`DMAC_SIZE_BITS-1:0]  size
    );
        logic [`DMAC_ADDR_WIDTH-1:0] step;
        if (burst == BURST_FIXED) begin
            step = '0;
        end else begin
            step = `DMAC_ADDR_WIDTH'(1) << size;
        end
        return step;
    endfunction

endpackage

/* hdl/dmac_regs.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_regs (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          reg_we_i,
    input  logic [`DMAC_ADDR_WIDTH-1:0]   reg_addr_i,
    input  logic [`DMAC_DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic                          done_i,
    output logic                          start_o,
    output logic                          busy_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   src_addr_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   dst_addr_o,
    output logic [`DMAC_LEN_BITS-1:0]     len_o,
    output logic [`DMAC_SIZE_BITS-1:0]    size_o,
    output dmac_pkg::burst_e              burst_o
);

    logic start_q;
    logic busy_q;
    logic start_set;
    logic cfg_we;

    // Config registers are frozen while a transfer runs
    assign cfg_we    = reg_we_i && !busy_o;
    assign start_set = cfg_we && (reg_addr_i == `DMAC_REG_VALID) && reg_wdata_i[0];

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            start_q    <= 1'b0;
            busy_q     <= 1'b0;
            src_addr_o <= '0;
            dst_addr_o <= '0;
            len_o      <= '0;
            size_o     <= '0;
            burst_o    <= dmac_pkg::BURST_FIXED;
        end else begin
            start_q <= start_set;
            if (start_set) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
            if (cfg_we && reg_addr_i == `DMAC_REG_SRC) begin
                src_addr_o <= reg_wdata_i;
            end
            if (cfg_we && reg_addr_i == `DMAC_REG_DST) begin
                dst_addr_o <= reg_wdata_i;
            end
            if (cfg_we && reg_addr_i == `DMAC_REG_CONFIG) begin
                len_o   <= reg_wdata_i[`DMAC_CFG_LEN_LSB +: `DMAC_LEN_BITS];
                size_o  <= reg_wdata_i[`DMAC_CFG_SIZE_LSB +: `DMAC_SIZE_BITS];
                burst_o <= dmac_pkg::burst_e'(reg_wdata_i[`DMAC_CFG_BURST_LSB +: `DMAC_BURST_BITS]);
            end
        end
    end

    assign start_o = start_q;
    // Drops in the done cycle itself
    assign busy_o  = busy_q && !done_i;

    done_while_busy_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        done_i |-> busy_q);

endmodule

/* hdl/dmac_read.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_read (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          start_i,
    input  logic [`DMAC_ADDR_WIDTH-1:0]   src_addr_i,
    input  logic [`DMAC_LEN_BITS-1:0]     len_i,
    input  logic [`DMAC_SIZE_BITS-1:0]    size_i,
    input  dmac_pkg::burst_e              burst_i,
    input  logic [`DMAC_CNT_BITS-1:0]     fifo_count_i,
    input  logic                          rd_valid_i,
    input  dmac_pkg::word_t               rd_data_i,
    output logic                          rd_req_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   rd_addr_o,
    output logic                          push_o,
    output dmac_pkg::word_t               push_data_o
);

    localparam int CW = `DMAC_CNT_BITS;
    localparam logic [CW:0] MAX_CREDITS = `DMAC_FIFO_DEPTH;

    logic [`DMAC_LEN_BITS-1:0]   remaining_q;
    logic [CW-1:0]               outstanding_q;
    logic [CW:0]                 credits;
    logic                        issue;
    logic                        req_next;
    logic                        req_q;
    logic [`DMAC_ADDR_WIDTH-1:0] addr_q;

    // In-flight requests plus beats already parked in the FIFO
    assign credits  = {1'b0, outstanding_q} + {1'b0, fifo_count_i};
    assign issue    = (remaining_q != '0) && (credits < MAX_CREDITS);
    assign req_next = start_i || issue;

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            req_q         <= 1'b0;
            remaining_q   <= '0;
            outstanding_q <= '0;
        end else begin
            req_q         <= req_next;
            outstanding_q <= outstanding_q + CW'(req_next) - CW'(rd_valid_i);
            // First beat goes out with start, len more to follow
            if (start_i) begin
                remaining_q <= len_i;
            end else if (issue) begin
                remaining_q <= remaining_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q <= src_addr_i;
        end else if (issue) begin
            addr_q <= addr_q + dmac_pkg::addr_step(burst_i, size_i);
        end
    end

    assign rd_req_o  = req_q;
    assign rd_addr_o = addr_q;

    // Returned beats go straight into the FIFO so credits stay balanced
    assign push_o      = rd_valid_i;
    assign push_data_o = rd_data_i;

    credit_limit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credits <= MAX_CREDITS);

    rd_valid_expected_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd_valid_i |-> outstanding_q != '0);

endmodule

/* hdl/dmac_fifo.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_fifo #(
    parameter type         T     = dmac_pkg::word_t,
    parameter int unsigned DEPTH = `DMAC_FIFO_DEPTH
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         push_i,
    input  T                             push_data_i,
    input  logic                         pop_i,
    output T                             pop_data_o,
    output logic                         empty_o,
    output logic [$clog2(DEPTH+1)-1:0]   count_o
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

    T              mem_q [DEPTH];
    logic [PW-1:0] wr_ptr_q;
    logic [PW-1:0] rd_ptr_q;
    logic [CW-1:0] count_q;
    logic          full;

    assign full = (count_q == CW'(DEPTH));

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CW'(push_i) - CW'(pop_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // Head entry is visible without a read cycle
    assign pop_data_o = mem_q[rd_ptr_q];
    assign empty_o    = (count_q == '0);
    assign count_o    = count_q;

    no_overflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> !full);

    no_underflow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_i |-> !empty_o);

endmodule

/* hdl/dmac_write.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_write (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          start_i,
    input  logic [`DMAC_ADDR_WIDTH-1:0]   dst_addr_i,
    input  logic [`DMAC_LEN_BITS-1:0]     len_i,
    input  logic [`DMAC_SIZE_BITS-1:0]    size_i,
    input  dmac_pkg::burst_e              burst_i,
    input  logic                          fifo_empty_i,
    input  dmac_pkg::word_t               fifo_data_i,
    output logic                          pop_o,
    output logic                          wr_en_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   wr_addr_o,
    output dmac_pkg::word_t               wr_data_o,
    output logic                          done_o
);

    logic [`DMAC_LEN_BITS:0]     beats_q;
    logic [`DMAC_ADDR_WIDTH-1:0] addr_q;
    logic                        wr_en_q;
    logic                        last_q;
    logic                        done_q;
    logic                        pop;

    assign pop = !fifo_empty_i && (beats_q != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_ni) begin
            beats_q <= '0;
            wr_en_q <= 1'b0;
            last_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            if (start_i) begin
                beats_q <= {1'b0, len_i} + 1'b1;
            end else if (pop) begin
                beats_q <= beats_q - 1'b1;
            end
            wr_en_q <= pop;
            // Marks the final write, done follows a cycle later
            last_q  <= pop && (beats_q == 1);
            done_q  <= last_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            addr_q <= dst_addr_i;
        end else if (pop) begin
            addr_q <= addr_q + dmac_pkg::addr_step(burst_i, size_i);
        end
        if (pop) begin
            wr_addr_o <= addr_q;
            wr_data_o <= fifo_data_i;
        end
    end

    assign pop_o   = pop;
    assign wr_en_o = wr_en_q;
    assign done_o  = done_q;

endmodule

/* hdl/dmac_top.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          reg_we_i,
    input  logic [`DMAC_ADDR_WIDTH-1:0]   reg_addr_i,
    input  logic [`DMAC_DATA_WIDTH-1:0]   reg_wdata_i,
    input  logic                          rd_valid_i,
    input  dmac_pkg::word_t               rd_data_i,
    output logic                          rd_req_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   rd_addr_o,
    output logic                          wr_en_o,
    output logic [`DMAC_ADDR_WIDTH-1:0]   wr_addr_o,
    output dmac_pkg::word_t               wr_data_o,
    output logic                          done_o,
    output logic                          busy_o
);

    logic                        start;
    logic [`DMAC_ADDR_WIDTH-1:0] src_addr;
    logic [`DMAC_ADDR_WIDTH-1:0] dst_addr;
    logic [`DMAC_LEN_BITS-1:0]   len;
    logic [`DMAC_SIZE_BITS-1:0]  size;
    dmac_pkg::burst_e            burst;
    logic                        push;
    dmac_pkg::word_t             push_data;
    logic                        pop;
    dmac_pkg::word_t             pop_data;
    logic                        fifo_empty;
    logic [`DMAC_CNT_BITS-1:0]   fifo_count;

    dmac_regs u_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .done_i      (done_o),
        .start_o     (start),
        .busy_o      (busy_o),
        .src_addr_o  (src_addr),
        .dst_addr_o  (dst_addr),
        .len_o       (len),
        .size_o      (size),
        .burst_o     (burst)
    );

    dmac_read u_read (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .src_addr_i   (src_addr),
        .len_i        (len),
        .size_i       (size),
        .burst_i      (burst),
        .fifo_count_i (fifo_count),
        .rd_valid_i   (rd_valid_i),
        .rd_data_i    (rd_data_i),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .push_o       (push),
        .push_data_o  (push_data)
    );

    dmac_fifo #(
        .T     (dmac_pkg::word_t),
        .DEPTH (`DMAC_FIFO_DEPTH)
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (push),
        .push_data_i (push_data),
        .pop_i       (pop),
        .pop_data_o  (pop_data),
        .empty_o     (fifo_empty),
        .count_o     (fifo_count)
    );

    dmac_write u_write (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .dst_addr_i   (dst_addr),
        .len_i        (len),
        .size_i       (size),
        .burst_i      (burst),
        .fifo_empty_i (fifo_empty),
        .fifo_data_i  (pop_data),
        .pop_o        (pop),
        .wr_en_o      (wr_en_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .done_o       (done_o)
    );

endmodule

/* dv/dmac_tb.sv */
`timescale 1ns/1ps
`include "dmac_consts.svh"

module dmac_tb;

    logic                        clk_i       = 1'b0;
    logic                        rst_ni      = 1'b0;
    logic                        reg_we_i    = 1'b0;
    logic [`DMAC_ADDR_WIDTH-1:0] reg_addr_i  = '0;
    logic [`DMAC_DATA_WIDTH-1:0] reg_wdata_i = '0;
    logic                        rd_valid_i  = 1'b0;
    logic [`DMAC_DATA_WIDTH-1:0] rd_data_i   = '0;
    logic                        rd_req_o;
    logic [`DMAC_ADDR_WIDTH-1:0] rd_addr_o;
    logic                        wr_en_o;
    logic [`DMAC_ADDR_WIDTH-1:0] wr_addr_o;
    logic [`DMAC_DATA_WIDTH-1:0] wr_data_o;
    logic                        done_o;
    logic                        busy_o;

    // Transfer table with one entry per row in every queue
    string                       tname[$];
    logic [31:0]                 tsrc[$];
    logic [31:0]                 tdst[$];
    logic [`DMAC_LEN_BITS-1:0]   tlen[$];
    logic [`DMAC_SIZE_BITS-1:0]  tsize[$];
    dmac_pkg::burst_e            tburst[$];
    logic                        table_ready = 1'b0;

    // Memory model and logs
    logic [31:0]                 src_mem[logic [31:0]];
    logic [31:0]                 dst_mem[logic [31:0]];
    logic [31:0]                 req_addr_q[$];
    int unsigned                 req_due_q[$];
    logic [31:0]                 rd_addr_log[$];
    logic [31:0]                 wr_addr_log[$];
    logic [31:0]                 wr_data_log[$];
    int unsigned                 cycle = 0;
    int                          outstanding = 0;
    int                          max_outstanding = 0;
    int                          done_count = 0;
    logic                        busy_prev = 1'b0;
    string                       cur_name = "reset";

    dmac_top u_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .reg_we_i    (reg_we_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .rd_valid_i  (rd_valid_i),
        .rd_data_i   (rd_data_i),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .wr_en_o     (wr_en_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("error %s: %s expected %h actual %h", cur_name, what, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] src, input logic [31:0] dst,
                           input logic [`DMAC_LEN_BITS-1:0] len,
                           input logic [`DMAC_SIZE_BITS-1:0] size,
                           input dmac_pkg::burst_e burst);
        tname.push_back(name);
        tsrc.push_back(src);
        tdst.push_back(dst);
        tlen.push_back(len);
        tsize.push_back(size);
        tburst.push_back(burst);
    endtask

    task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk_i);
        reg_we_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        @(posedge clk_i);
        reg_we_i    <= 1'b0;
    endtask

    function automatic logic [31:0] source_value(input logic [31:0] addr);
        return 32'hA500_0000 + addr;
    endfunction

    // Byte offset of beat i with 2**size bytes per beat unless FIXED
    function automatic logic [31:0] beat_offset(input int i,
                                                input logic [`DMAC_SIZE_BITS-1:0] size,
                                                input dmac_pkg::burst_e burst);
        logic [31:0] off;
        if (burst == dmac_pkg::BURST_FIXED) begin
            off = '0;
        end else begin
            off = 32'(i) << size;
        end
        return off;
    endfunction

    function automatic logic [31:0] config_word(input logic [`DMAC_LEN_BITS-1:0] len,
                                                input logic [`DMAC_SIZE_BITS-1:0] size,
                                                input dmac_pkg::burst_e burst);
        return (32'(len) << `DMAC_CFG_LEN_LSB) | (32'(size) << `DMAC_CFG_SIZE_LSB) |
               (32'(burst) << `DMAC_CFG_BURST_LSB);
    endfunction

    function automatic int total_beats();
        int sum;
        sum = 0;
        foreach (tlen[r]) begin
            sum = sum + int'(tlen[r]) + 1;
        end
        return sum;
    endfunction

    // Memory model and port monitor
    always @(posedge clk_i) begin
        logic [31:0] a;
        rd_valid_i <= 1'b0;
        if (rst_ni) begin
            if (rd_valid_i) begin
                outstanding = outstanding - 1;
            end
            if (rd_req_o) begin
                rd_addr_log.push_back(rd_addr_o);
                req_addr_q.push_back(rd_addr_o);
                // A delay of 1 puts rd_valid_i in the very next cycle
                req_due_q.push_back(cycle + $urandom_range(4, 1) - 1);
                outstanding = outstanding + 1;
            end
            if (req_addr_q.size() > 0 && cycle >= req_due_q[0]) begin
                a = req_addr_q.pop_front();
                void'(req_due_q.pop_front());
                if (!src_mem.exists(a)) begin
                    $display("Read request to an unfilled source address %h", a);
                    $display("Test FAILED");
                    $fatal(1, "bad read address");
                end else begin
                    rd_valid_i <= 1'b1;
                    rd_data_i  <= src_mem[a];
                end
            end
            if (outstanding > max_outstanding) begin
                max_outstanding = outstanding;
            end
            if (wr_en_o) begin
                wr_addr_log.push_back(wr_addr_o);
                wr_data_log.push_back(wr_data_o);
                dst_mem[wr_addr_o] = wr_data_o;
            end
            if (done_o) begin
                done_count = done_count + 1;
                check("busy_o in done cycle", 32'h0, 32'(busy_o));
                check("busy_o before done", 32'h1, 32'(busy_prev));
            end
            busy_prev = busy_o;
        end
        cycle = cycle + 1;
    end

    // Watchdog scaled by the table length
    initial begin
        int unsigned limit;
        wait (table_ready);
        limit = 200 * total_beats();
        repeat (limit) @(posedge clk_i);
        $display("Timeout, done_o never arrived within %0d cycles", limit);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          beats;
        logic [31:0] a;
        logic [31:0] off;
        void'($urandom(95));
        add_row("incr_copy_8",    32'h0000_1000, 32'h0000_8000, 8'd7,   3'd2, dmac_pkg::BURST_INCR);
        add_row("fixed_burst_4",  32'h0000_2040, 32'h0000_9000, 8'd3,   3'd2, dmac_pkg::BURST_FIXED);
        add_row("byte_step_6",    32'h0000_3001, 32'h0000_A003, 8'd5,   3'd0, dmac_pkg::BURST_INCR);
        add_row("slow_memory_16", 32'h0000_4000, 32'h0000_B000, 8'd15,  3'd2, dmac_pkg::BURST_INCR);
        add_row("long_copy_256",  32'h0001_0000, 32'h0002_0000, 8'd255, 3'd2, dmac_pkg::BURST_INCR);
        table_ready = 1'b1;

        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int r = 0; r < tname.size(); r++) begin
            cur_name = tname[r];
            beats    = int'(tlen[r]) + 1;
            for (int i = 0; i < beats; i++) begin
                a = tsrc[r] + beat_offset(i, tsize[r], tburst[r]);
                src_mem[a] = source_value(a);
            end
            rd_addr_log.delete();
            wr_addr_log.delete();
            wr_data_log.delete();
            done_count      = 0;
            max_outstanding = 0;

            reg_write(`DMAC_REG_SRC, tsrc[r]);
            reg_write(`DMAC_REG_DST, tdst[r]);
            reg_write(`DMAC_REG_CONFIG, config_word(tlen[r], tsize[r], tburst[r]));
            reg_write(`DMAC_REG_VALID, 32'h1);
            @(posedge clk_i);
            check("busy_o after start", 32'h1, 32'(busy_o));
            // Second start while busy must be dropped
            reg_write(`DMAC_REG_VALID, 32'h1);
            do begin
                @(posedge clk_i);
            end while (!done_o);
            // Room for a stray second transfer to show up
            repeat (20) @(posedge clk_i);

            check("done_o pulses", 32'h1, done_count);
            check("read requests", beats, rd_addr_log.size());
            check("memory writes", beats, wr_addr_log.size());
            check("requests left open", 32'h0, outstanding);
            check("outstanding within FIFO depth", 32'h1,
                  32'(max_outstanding <= `DMAC_FIFO_DEPTH));
            for (int i = 0; i < beats; i++) begin
                off = beat_offset(i, tsize[r], tburst[r]);
                check($sformatf("rd_addr beat %0d", i), tsrc[r] + off, rd_addr_log[i]);
                check($sformatf("wr_addr beat %0d", i), tdst[r] + off, wr_addr_log[i]);
                check($sformatf("wr_data beat %0d", i), source_value(tsrc[r] + off),
                      wr_data_log[i]);
                check($sformatf("dst word beat %0d", i), source_value(tsrc[r] + off),
                      dst_mem[tdst[r] + off]);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

/* all.f */
+incdir+hdl
hdl/dmac_pkg.sv
hdl/dmac_regs.sv
hdl/dmac_read.sv
hdl/dmac_fifo.sv
hdl/dmac_write.sv
hdl/dmac_top.sv
dv/dmac_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := dmac_tb
FILELIST   := all.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
